// ==== project.f ====
+incdir+hw
hw/ifu_pkg.sv
hw/sync_fifo.sv
hw/burst_beat_counter.sv
hw/fetch_fsm.sv
hw/instr_slot_extract.sv
hw/ifu_mem_ctrl.sv
tests/tb_clock_gen.sv
tests/axi_rd_mem_model.sv
tests/ifu_mem_ctrl_tb.sv

// ==== Makefile ====
# Verilator simulation of the fetch unit memory side.

TOP := ifu_mem_ctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

clean:
	rm -rf obj_dir

// ==== tests/ifu_mem_ctrl_tb.sv ====
/////////////////////////////////
// testbench for the fetch unit
// memory side.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module ifu_mem_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] MIX = 32'h9E37_79B1;
  localparam logic [31:0] PC0 = 32'h0000_1236;
  localparam logic [31:0] PC1 = 32'h0000_8A4E;

  logic        clk;
  logic        rst_n;
  logic        redirect;
  logic [31:1] pc;
  logic        stall;
  logic [31:0] instr;
  logic        instr_valid;
  logic        compressed;
  logic        start_fetch;
  logic        done_fetch;

  logic [`IFU_AXI_ID_W-1:0] arid;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic        arlock;
  logic [3:0]  arcache;
  logic [2:0]  arprot;
  logic [3:0]  arqos;
  logic [3:0]  arregion;
  logic        arvalid;
  logic        arready;
  logic [`IFU_AXI_ID_W-1:0] rid;
  logic [63:0] rdata;
  logic [1:0]  rresp;
  logic        rlast;
  logic        rvalid;
  logic        rready;

  logic [31:0] slot_q[$];
  logic [31:0] exp_ar;
  logic [31:0] exp_slot;
  logic [31:0] new_base;
  logic        skip_ok;
  int          consumed;
  int          start_cnt;
  int          done_cnt;
  int          err_cnt;
  int          base_err;
  int          pass_cnt;
  int          fail_cnt;

  tb_clock_gen clock_gen_0 (.clk(clk), .rst_n(rst_n));

  axi_rd_mem_model mem_0 (
    .clk(clk), .rst_n(rst_n), .arvalid(arvalid), .araddr(araddr), .arlen(arlen),
    .arready(arready), .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast),
    .rvalid(rvalid), .rready(rready)
  );

  ifu_mem_ctrl dut0 (
    .clk(clk), .rst_n(rst_n), .redirect(redirect), .pc(pc), .stall(stall),
    .instr(instr), .instr_valid(instr_valid), .compressed(compressed),
    .start_fetch(start_fetch), .done_fetch(done_fetch),
    .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
    .arlock(arlock), .arcache(arcache), .arprot(arprot), .arqos(arqos),
    .arregion(arregion), .arvalid(arvalid), .arready(arready),
    .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid),
    .rready(rready)
  );

  // slot at byte address a, low bits alternate per beat.
  function automatic logic [31:0] expected_slot(input logic [31:0] a);
    logic [31:0] p;
    p = a * MIX;
    return {p[31:2], (a[3] ? 2'b01 : 2'b11)};
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      consumed <= 0;
      skip_ok  <= 1'b0;
      a_reset: assert (!arvalid && !instr_valid && !start_fetch && !done_fetch &&
                       instr == `IFU_NOP)
        else report_error("outputs not idle during reset");
    end else begin
      if (!instr_valid) begin
        a_nop: assert (instr == `IFU_NOP) else mismatch("instr", instr, `IFU_NOP);
        a_cidle: assert (!compressed)
          else mismatch("compressed", 32'(compressed), 32'd0);
      end
      if (arvalid && arready) begin
        a_araddr: assert (araddr == exp_ar) else mismatch("araddr", araddr, exp_ar);
        a_arlen: assert (arlen == 8'd7) else mismatch("arlen", 32'(arlen), 32'd7);
        a_arsize: assert (arsize == 3'b011) else mismatch("arsize", 32'(arsize), 32'd3);
        a_arburst: assert (arburst == 2'b01)
          else mismatch("arburst", 32'(arburst), 32'd1);
        a_arside: assert ({arid, arlock, arcache, arprot, arqos, arregion} == '0)
          else mismatch("ar side-band",
                        32'({arid, arlock, arcache, arprot, arqos, arregion}), 32'd0);
        for (int i = 0; i < 2 * `IFU_BURST_LEN; i++) begin
          slot_q.push_back(araddr + 32'(i * 4));
        end
        exp_ar = exp_ar + 32'd64;
      end
      if (start_fetch) begin
        a_start: assert (start_cnt == done_cnt) else report_error("start_fetch without done");
        start_cnt++;
      end
      if (done_fetch) begin
        a_done: assert (start_cnt == done_cnt + 1) else report_error("extra done_fetch");
        done_cnt++;
      end
      if (instr_valid && !stall) begin
        // slots ahead of a redirect may be dropped by the flush.
        if (skip_ok && slot_q.size() > 0 && instr != expected_slot(slot_q[0])) begin
          while (slot_q.size() > 0 && slot_q[0] != new_base) begin
            void'(slot_q.pop_front());
          end
        end
        if (slot_q.size() == 0) begin
          report_error("valid slot with no slot expected");
        end else begin
          exp_slot = expected_slot(slot_q[0]);
          if (slot_q[0] == new_base) skip_ok <= 1'b0;
          a_slot: assert (instr == exp_slot)
            else mismatch("instr", instr, exp_slot);
          a_cflag: assert (compressed == (exp_slot[1:0] != 2'b11))
            else mismatch("compressed", 32'(compressed), 32'(exp_slot[1:0] != 2'b11));
          void'(slot_q.pop_front());
          consumed <= consumed + 1;
        end
      end
      if (redirect) begin
        exp_ar   = {pc[31:3], 3'b000};
        new_base = {pc[31:3], 3'b000};
        skip_ok  <= 1'b1;
      end
    end
  end

  task automatic finish_test(input string name);
    if (err_cnt == base_err) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors", name, err_cnt - base_err);
    end
    base_err = err_cnt;
  endtask

  task automatic wait_slots(input int n);
    int target;
    int cycles;
    target = consumed + n;
    cycles = 0;
    while (consumed < target && cycles < 4000) begin
      @(posedge clk);
      cycles++;
    end
    if (consumed < target) report_error("timed out waiting for slots");
  endtask

  task automatic wait_rready_low();
    int cycles;
    cycles = 0;
    while (rready && cycles < 1000) begin
      @(posedge clk);
      cycles++;
    end
    if (rready) report_error("rready never fell under stall");
  endtask

  task automatic wait_beat();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!(rvalid && rready) && cycles < 1000);
    if (!(rvalid && rready)) report_error("no read beat accepted");
  endtask

  task automatic wait_new_stream();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (skip_ok && cycles < 2000);
    if (skip_ok) report_error("no slot from the redirect address");
  endtask

  initial begin : stimulus
    int cycles;
    redirect = 1'b1;
    pc       = PC0[31:1];
    stall    = 1'b0;
    exp_ar   = '0;
    exp_slot = '0;
    new_base = '0;
    start_cnt = 0;
    done_cnt = 0;
    err_cnt  = 0;
    base_err = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    // redirect is held through reset and taken on the first active edge.
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!rst_n && cycles < 20);
    if (!rst_n) report_error("reset never released");
    redirect <= 1'b0;
    finish_test("reset state");

    wait_slots(64);
    finish_test("burst issue, slot order and compressed flag");

    stall <= 1'b1;
    wait_rready_low();
    repeat (20) @(posedge clk);
    stall <= 1'b0;
    wait_slots(48);
    finish_test("stall back-pressure");

    wait_beat();
    redirect <= 1'b1;
    pc       <= PC1[31:1];
    @(posedge clk);
    redirect <= 1'b0;
    wait_new_stream();
    wait_slots(32);
    finish_test("redirect");

    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/axi_rd_mem_model.sv ====
/////////////////////////////////
// AXI read slave with a computed
// memory image and random gaps.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module axi_rd_mem_model (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     arvalid,
  input  logic [31:0]              araddr,
  input  logic [7:0]               arlen,
  output logic                     arready,
  output logic [`IFU_AXI_ID_W-1:0] rid,
  output logic [63:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rlast,
  output logic                     rvalid,
  input  logic                     rready
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] MIX = 32'h9E37_79B1;

  logic [31:0] seed;
  logic [31:0] base;
  logic [7:0]  beat;
  logic [7:0]  last_beat;
  logic        busy;
  logic [1:0]  gap;

  // each half is its byte address times an odd constant.
  function automatic logic [31:0] half_word(input logic [31:0] a);
    logic [31:0] p;
    p = a * MIX;
    return {p[31:2], (a[3] ? 2'b01 : 2'b11)};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign rid   = '0;
  assign rresp = 2'b00;

  always @(posedge clk or negedge rst_n) begin : step
    logic [31:0] nxt;
    logic [31:0] addr;
    nxt  = lcg_next(seed);
    addr = base + {21'b0, beat, 3'b000};
    if (!rst_n) begin
      seed      <= 32'd23326;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rlast     <= 1'b0;
      rdata     <= '0;
      busy      <= 1'b0;
      gap       <= 2'd0;
      beat      <= 8'd0;
      base      <= '0;
      last_beat <= 8'd0;
    end else if (!busy) begin
      if (arvalid && arready) begin
        arready   <= 1'b0;
        busy      <= 1'b1;
        base      <= araddr;
        beat      <= 8'd0;
        last_beat <= arlen;
        seed      <= nxt;
        gap       <= nxt[17:16];
      end else if (gap != 2'd0) begin
        gap <= gap - 2'd1;
      end else begin
        arready <= 1'b1;
      end
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      rlast  <= 1'b0;
      seed   <= nxt;
      gap    <= nxt[17:16];
      if (rlast) begin
        busy <= 1'b0;
      end else begin
        beat <= beat + 8'd1;
      end
    end else if (!rvalid) begin
      if (gap != 2'd0) begin
        gap <= gap - 2'd1;
      end else begin
        rvalid <= 1'b1;
        rdata  <= {half_word(addr + 32'd4), half_word(addr)};
        rlast  <= (beat == last_beat);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
/////////////////////////////////
// testbench clock, 40 ns period,
// and active-low reset.
/////////////////////////////////

`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/ifu_mem_ctrl.sv ====
/////////////////////////////////
// ifu_mem_ctrl: AXI burst fetch
// into a FIFO, 32-bit slots out.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module ifu_mem_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        redirect,
  input  logic [31:1]                 pc,
  input  logic                        stall,
  output ifu_pkg::instr_slot_t        instr,
  output logic                        instr_valid,
  output logic                        compressed,
  output logic                        start_fetch,
  output logic                        done_fetch,

  // read address channel.
  output logic [`IFU_AXI_ID_W-1:0]    arid,
  output logic [31:0]                 araddr,
  output logic [7:0]                  arlen,
  output logic [2:0]                  arsize,
  output logic [1:0]                  arburst,
  output logic                        arlock,
  output logic [3:0]                  arcache,
  output logic [2:0]                  arprot,
  output logic [3:0]                  arqos,
  output logic [3:0]                  arregion,
  output logic                        arvalid,
  input  logic                        arready,

  // read data channel, rid and rresp are not checked.
  input  logic [`IFU_AXI_ID_W-1:0]    rid,
  input  ifu_pkg::fetch_word_t        rdata,
  input  logic [1:0]                  rresp,
  input  logic                        rlast,
  input  logic                        rvalid,
  output logic                        rready
);
  import ifu_pkg::*;

  localparam int          CNT_W      = $clog2(`IFU_FIFO_DEPTH + 1);
  localparam logic [2:0]  SIZE_8B    = 3'b011;
  localparam logic [1:0]  BURST_INCR = 2'b01;

  logic             beat_accept;
  logic             burst_done;
  logic             fifo_flush;
  logic             fifo_full;
  logic             fifo_empty;
  logic             fifo_pop;
  logic [CNT_W-1:0] free_count;
  fetch_word_t      fifo_word;

  assign rready      = !fifo_full;
  assign beat_accept = rvalid && rready;

  fetch_fsm fetch_fsm_0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect   (redirect),
    .pc         (pc),
    .free_count (free_count),
    .arready    (arready),
    .burst_done (burst_done),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .start_fetch(start_fetch),
    .done_fetch (done_fetch),
    .flush      (fifo_flush)
  );

  burst_beat_counter burst_beat_counter_0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_fetch(start_fetch),
    .beat_accept(beat_accept),
    .rlast      (rlast),
    .burst_done (burst_done)
  );

  sync_fifo #(
    .payload_t(fetch_word_t),
    .DEPTH    (`IFU_FIFO_DEPTH)
  ) sync_fifo_0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (fifo_flush),
    .push      (beat_accept),
    .wdata     (rdata),
    .pop       (fifo_pop),
    .rdata     (fifo_word),
    .full      (fifo_full),
    .empty     (fifo_empty),
    .free_count(free_count)
  );

  instr_slot_extract instr_slot_extract_0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (fifo_flush),
    .empty      (fifo_empty),
    .word       (fifo_word),
    .stall      (stall),
    .pop        (fifo_pop),
    .instr      (instr),
    .instr_valid(instr_valid),
    .compressed (compressed)
  );

  // fixed burst shape.
  assign arlen    = 8'(`IFU_BURST_LEN - 1);
  assign arsize   = SIZE_8B;
  assign arburst  = BURST_INCR;

  assign arid     = '0;
  assign arlock   = 1'b0;
  assign arcache  = '0;
  assign arprot   = '0;
  assign arqos    = '0;
  assign arregion = '0;

endmodule

`default_nettype wire

// ==== hw/instr_slot_extract.sv ====
/////////////////////////////////
// instr_slot_extract: splits FIFO
// words into 32-bit slots.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module instr_slot_extract (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 empty,
  input  ifu_pkg::fetch_word_t word,
  input  logic                 stall,
  output logic                 pop,
  output ifu_pkg::instr_slot_t instr,
  output logic                 instr_valid,
  output logic                 compressed
);
  import ifu_pkg::*;

  instr_slot_t slot;
  logic        half_q;
  logic        advance;

  // low half first.
  assign slot = half_q ? word[63:32] : word[31:0];

  // a slot on a flush cycle is stale.
  assign instr_valid = !empty && !flush;
  assign advance     = instr_valid && !stall;

  // word leaves with its high slot.
  assign pop = advance && half_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (flush) begin
      half_q <= 1'b0;
    end else if (advance) begin
      half_q <= ~half_q;
    end
  end

  assign instr      = instr_valid ? slot : `IFU_NOP;
  assign compressed = instr_valid && (slot[1:0] != 2'b11);

  // a stalled slot stays put unless a redirect flushes it.
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (stall && instr_valid && !flush) ##1 !flush |-> instr_valid && $stable(instr))
    else $error("instr_slot_extract: slot changed under stall");

endmodule

`default_nettype wire

// ==== hw/fetch_fsm.sv ====
/////////////////////////////////
// fetch_fsm: AXI read address FSM,
// fetch address and redirects.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module fetch_fsm (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 redirect,
  input  logic [31:1]                          pc,
  input  logic [$clog2(`IFU_FIFO_DEPTH+1)-1:0] free_count,
  input  logic                                 arready,
  input  logic                                 burst_done,
  output logic                                 arvalid,
  output logic [31:0]                          araddr,
  output logic                                 start_fetch,
  output logic                                 done_fetch,
  output logic                                 flush
);
  import ifu_pkg::*;

  localparam int CNT_W = $clog2(`IFU_FIFO_DEPTH + 1);

  fetch_state_t state_q;
  fetch_state_t state_d;
  logic [31:3]  fetch_addr_q;
  logic [31:3]  pend_addr_q;
  logic         pend_q;
  logic         stale_q;
  logic         apply_redirect;
  logic [31:3]  new_addr;
  logic         ar_hs;

  assign ar_hs = arvalid && arready;

  // a fresh redirect beats one held from the last burst.
  assign apply_redirect = (state_q != DATA) && (redirect || pend_q);
  assign new_addr       = redirect ? pc[31:3] : pend_addr_q;

  assign start_fetch = (state_q == IDLE) && !apply_redirect &&
                       (free_count >= CNT_W'(`IFU_BURST_LEN));
  assign done_fetch  = (state_q == DATA) && burst_done;

  // beats of a burst issued before a redirect are dropped as they land.
  assign flush = apply_redirect || (stale_q && (state_q == DATA));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_fetch) state_d = ADDR;
      ADDR:    if (ar_hs) state_d = DATA;
      DATA:    if (burst_done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      fetch_addr_q <= '0;
      pend_addr_q  <= '0;
      pend_q       <= 1'b0;
      stale_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (apply_redirect) begin
        fetch_addr_q <= new_addr;
      end else if (done_fetch && !stale_q) begin
        fetch_addr_q <= fetch_addr_q + 29'(`IFU_BURST_LEN);
      end
      if ((state_q == DATA) && redirect) begin
        pend_q      <= 1'b1;
        pend_addr_q <= pc[31:3];
      end else if (apply_redirect) begin
        pend_q <= 1'b0;
      end
      if (apply_redirect && (state_q == ADDR)) begin
        stale_q <= 1'b1;
      end else if (done_fetch) begin
        stale_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arvalid <= 1'b0;
      araddr  <= '0;
    end else if (start_fetch) begin
      arvalid <= 1'b1;
      araddr  <= {fetch_addr_q, 3'b000};
    end else if (ar_hs) begin
      arvalid <= 1'b0;
    end
  end

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid && !arready) |=> (arvalid && $stable(araddr)))
    else $error("fetch_fsm: araddr changed in %s before handshake", state_q.name());

endmodule

`default_nettype wire

// ==== hw/burst_beat_counter.sv ====
/////////////////////////////////
// burst_beat_counter: counts read
// beats, flags the final one.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module burst_beat_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic start_fetch,
  input  logic beat_accept,
  input  logic rlast,
  output logic burst_done
);

  localparam int CNT_W = $clog2(`IFU_BURST_LEN + 1);

  logic [CNT_W-1:0] beat_cnt;
  logic             last_beat;

  // final beat of the burst.
  assign last_beat = beat_accept && (beat_cnt == CNT_W'(`IFU_BURST_LEN - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (start_fetch) begin
      beat_cnt <= '0;
    end else if (beat_accept) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign burst_done = last_beat;

  // slave must agree with our beat count.
  a_rlast_match: assert property (@(posedge clk) disable iff (!rst_n)
    beat_accept |-> (rlast == last_beat))
    else $error("burst_beat_counter: rlast does not match beat %0d", beat_cnt);

endmodule

`default_nettype wire

// ==== hw/sync_fifo.sv ====
/////////////////////////////////
// sync_fifo: flushable circular
// buffer, first-word fall-through.
/////////////////////////////////

`default_nettype none

`include "ifu_config.svh"

module sync_fifo #(
  parameter type payload_t = ifu_pkg::fetch_word_t,
  parameter int  DEPTH     = `IFU_FIFO_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       push,
  input  payload_t                   wdata,
  input  logic                       pop,
  output payload_t                   rdata,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] free_count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // flush drops both ports for the cycle.
  assign do_push = push && !flush;
  assign do_pop  = pop && !flush;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  assign rdata      = mem[rd_ptr];
  assign full       = (count == CNT_W'(DEPTH));
  assign empty      = (count == '0);
  assign free_count = CNT_W'(DEPTH) - count;

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full)
    else $error("sync_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty)
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== hw/ifu_pkg.sv ====
/////////////////////////////////
// fetch unit shared types: data
// words, slots and FSM states.
/////////////////////////////////

`default_nettype none

package ifu_pkg;

  // one AXI read beat.
  typedef logic [63:0] fetch_word_t;

  // one raw 32-bit instruction slot.
  typedef logic [31:0] instr_slot_t;

  // address channel FSM.
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ADDR = 2'b01,
    DATA = 2'b10
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== hw/ifu_config.svh ====
/////////////////////////////////
// fetch unit configuration: burst,
// FIFO and AXI sizing constants.
/////////////////////////////////

`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// beats per AXI burst, 64-bit beats.
`define IFU_BURST_LEN 8

// FIFO entries, at least one burst.
`define IFU_FIFO_DEPTH 16

// AXI id width.
`define IFU_AXI_ID_W 4

// addi x0, x0, 0.
`define IFU_NOP 32'h0000_0013

`endif
